/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] rv_instr_t;    // Raw instruction word
    typedef logic [4:0]  rv_reg_idx_t;  // Register file index
    typedef logic [6:0]  rv_opcode_t;   // Major opcode field
    typedef logic [2:0]  rv_funct3_t;
    typedef logic [6:0]  rv_funct7_t;

    // Major opcodes
    localparam rv_opcode_t RV_OPC_OP     = 7'b0110011;  // Register-register
    localparam rv_opcode_t RV_OPC_OP_IMM = 7'b0010011;  // Register-immediate

    // Funct3, Zbb group
    localparam rv_funct3_t RV_F3_ROL   = 3'b001;  // Also clz/ctz/cpop/sext slot
    localparam rv_funct3_t RV_F3_ROR   = 3'b101;  // Also rori, orc.b, rev8
    localparam rv_funct3_t RV_F3_MIN   = 3'b100;
    localparam rv_funct3_t RV_F3_MINU  = 3'b101;
    localparam rv_funct3_t RV_F3_MAX   = 3'b110;
    localparam rv_funct3_t RV_F3_MAXU  = 3'b111;
    localparam rv_funct3_t RV_F3_ZEXTH = 3'b100;

    // Funct3, Zbs group
    localparam rv_funct3_t RV_F3_BCLR = 3'b001;
    localparam rv_funct3_t RV_F3_BEXT = 3'b101;
    localparam rv_funct3_t RV_F3_BINV = 3'b001;
    localparam rv_funct3_t RV_F3_BSET = 3'b001;

    // Funct7, Zbb group
    localparam rv_funct7_t RV_F7_ROT    = 7'b0110000;  // Rotates and unary counts
    localparam rv_funct7_t RV_F7_MINMAX = 7'b0000101;
    localparam rv_funct7_t RV_F7_ZEXTH  = 7'b0000100;
    localparam rv_funct7_t RV_F7_ORCB   = 7'b0010100;  // Shared with bset
    localparam rv_funct7_t RV_F7_REV8   = 7'b0110100;  // Shared with binv

    // Funct7, Zbs group
    localparam rv_funct7_t RV_F7_BCLR = 7'b0100100;  // bclr and bext
    localparam rv_funct7_t RV_F7_BINV = 7'b0110100;
    localparam rv_funct7_t RV_F7_BSET = 7'b0010100;

    // Rs2 field selects inside the unary Zbb encodings
    localparam rv_reg_idx_t RV_RS2_CLZ   = 5'd0;
    localparam rv_reg_idx_t RV_RS2_CTZ   = 5'd1;
    localparam rv_reg_idx_t RV_RS2_CPOP  = 5'd2;
    localparam rv_reg_idx_t RV_RS2_SEXTB = 5'd4;
    localparam rv_reg_idx_t RV_RS2_SEXTH = 5'd5;
    localparam rv_reg_idx_t RV_RS2_ORCB  = 5'd7;
    localparam rv_reg_idx_t RV_RS2_REV8  = 5'd24;
    localparam rv_reg_idx_t RV_RS2_ZEXTH = 5'd0;

endpackage

/* rtl/bmu_pkg.sv */
package bmu_pkg;

    import rv_isa_pkg::*;

    typedef logic [31:0] bmu_word_t;  // Operand or result word
    typedef logic [4:0]  bmu_op_t;    // Unit operation code

    // Operation codes, Zbb
    localparam bmu_op_t BMU_OP_CLZ   = 5'd0;
    localparam bmu_op_t BMU_OP_CTZ   = 5'd1;   // Low bit picks reversed rs1
    localparam bmu_op_t BMU_OP_CPOP  = 5'd2;
    localparam bmu_op_t BMU_OP_ORCB  = 5'd3;
    localparam bmu_op_t BMU_OP_REV8  = 5'd4;
    localparam bmu_op_t BMU_OP_ZEXTH = 5'd5;   // Bit 1 clear, zero fill
    localparam bmu_op_t BMU_OP_SEXTB = 5'd6;
    localparam bmu_op_t BMU_OP_SEXTH = 5'd7;   // Bit 1 set, sign fill
    localparam bmu_op_t BMU_OP_ROL   = 5'd8;
    localparam bmu_op_t BMU_OP_ROR   = 5'd9;   // ror and rori
    localparam bmu_op_t BMU_OP_MAX   = 5'd10;
    localparam bmu_op_t BMU_OP_MAXU  = 5'd15;
    localparam bmu_op_t BMU_OP_MIN   = 5'd16;
    localparam bmu_op_t BMU_OP_MINU  = 5'd17;

    // Operation codes, Zbs, register and immediate forms alike
    localparam bmu_op_t BMU_OP_BCLR = 5'd11;
    localparam bmu_op_t BMU_OP_BEXT = 5'd12;
    localparam bmu_op_t BMU_OP_BINV = 5'd13;
    localparam bmu_op_t BMU_OP_BSET = 5'd14;

    // Item entering the unit
    typedef struct packed {
        logic      valid;
        rv_instr_t instr;
        bmu_word_t rs1_value;
        bmu_word_t rs2_value;  // Ignored by immediate forms
    } bmu_issue_t;

    // Item leaving the unit
    typedef struct packed {
        logic        valid;
        logic        illegal;  // Unsupported encoding, value forced to 0
        rv_reg_idx_t rd;
        bmu_word_t   value;
    } bmu_result_t;

endpackage

/* rtl/bmu_clz.sv */
`timescale 1ns/1ps

module bmu_clz import bmu_pkg::*; #(
    parameter int XLEN_ONES_W = 6
) (
    input  bmu_word_t              rs1_i,
    output logic [XLEN_ONES_W-1:0] count_o
);

    localparam int WORD_W = $bits(bmu_word_t);

    logic                   found;  // First set bit already seen
    logic [XLEN_ONES_W-1:0] count;

    // Priority scan, top bit first
    always_comb begin
        found = 1'b0;
        count = XLEN_ONES_W'(WORD_W);  // All zero gives full width
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (!found && rs1_i[i]) begin
                count = XLEN_ONES_W'(WORD_W - 1 - i);  // Zeros above bit i
                found = 1'b1;
            end
        end
    end

    assign count_o = count;

endmodule

/* rtl/bmu_cpop.sv */
`timescale 1ns/1ps

module bmu_cpop import bmu_pkg::*; #(
    parameter int XLEN_ONES_W = 6
) (
    input  bmu_word_t              rs1_value_i,
    output logic [XLEN_ONES_W-1:0] ones_count_o
);

    localparam int WORD_W = $bits(bmu_word_t);

    logic [XLEN_ONES_W-1:0] node [WORD_W];  // Tree nodes, reused per level

    // Pairwise adder tree, halves the node count per level
    always_comb begin
        for (int i = 0; i < WORD_W; i++) begin
            node[i] = XLEN_ONES_W'(rs1_value_i[i]);  // Leaves
        end
        for (int w = WORD_W / 2; w >= 1; w = w / 2) begin
            for (int j = 0; j < w; j++) begin
                node[j] = node[2*j] + node[2*j+1];  // Children sit at or above j
            end
        end
    end

    assign ones_count_o = node[0];  // Root of the tree

endmodule

/* rtl/bmu.sv */
`timescale 1ns/1ps

module bmu import bmu_pkg::*; #(
    parameter int XLEN_ONES_W = 6
) (
    input  bmu_word_t rs1_value_i,
    input  bmu_word_t rs2_value_i,
    input  bmu_op_t   bmu_opcode_i,
    output bmu_word_t bmu_result_o
);

    localparam int WORD_W = $bits(bmu_word_t);

    logic [4:0]             shamt;        // Bit index or rotate amount
    logic [5:0]             shamt_inv;    // Complementary rotate amount
    bmu_word_t              rs1_rev;      // Bit-reversed rs1
    bmu_word_t              clz_operand;  // rs1 or its reverse
    logic [XLEN_ONES_W-1:0] clz_ctz_res;
    logic [XLEN_ONES_W-1:0] cpop_res;
    logic                   ext_sign;     // Fill bit for zext.h / sext.h
    bmu_word_t              ext_h_res;
    bmu_word_t              sext_b_res;
    bmu_word_t              orc_b_res;
    bmu_word_t              rev8_res;
    bmu_word_t              rol_res;
    bmu_word_t              ror_res;
    bmu_word_t              bit_mask;     // One-hot at the selected index
    logic                   lt_signed;
    logic                   lt_unsigned;

    assign shamt     = rs2_value_i[4:0];
    assign shamt_inv = 6'(WORD_W) - {1'b0, shamt};  // 32 when shamt is 0

    // Bit and byte reordering
    always_comb begin
        for (int i = 0; i < WORD_W; i++) begin
            rs1_rev[i] = rs1_value_i[WORD_W-1-i];
        end
        for (int b = 0; b < WORD_W / 8; b++) begin
            orc_b_res[8*b +: 8] = {8{|rs1_value_i[8*b +: 8]}};      // Any bit set
            rev8_res[8*b +: 8]  = rs1_value_i[WORD_W-8-8*b +: 8];  // Byte swap
        end
    end

    // ctz is clz of the reversed word
    assign clz_operand = bmu_opcode_i[0] ? rs1_rev : rs1_value_i;

    bmu_clz #(
        .XLEN_ONES_W (XLEN_ONES_W)
    ) bmu_clz_i (
        .rs1_i   (clz_operand),
        .count_o (clz_ctz_res)
    );

    bmu_cpop #(
        .XLEN_ONES_W (XLEN_ONES_W)
    ) bmu_cpop_i (
        .rs1_value_i  (rs1_value_i),
        .ones_count_o (cpop_res)
    );

    // Half-word extender, sign only for sext.h
    assign ext_sign   = bmu_opcode_i[1] & rs1_value_i[15];
    assign ext_h_res  = {{16{ext_sign}}, rs1_value_i[15:0]};
    assign sext_b_res = {{24{rs1_value_i[7]}}, rs1_value_i[7:0]};

    // Rotates, shift by full width yields 0
    assign rol_res = (rs1_value_i << shamt) | (rs1_value_i >> shamt_inv);
    assign ror_res = (rs1_value_i >> shamt) | (rs1_value_i << shamt_inv);

    // Compares for min/max
    assign lt_signed   = $signed(rs1_value_i) < $signed(rs2_value_i);
    assign lt_unsigned = rs1_value_i < rs2_value_i;

    assign bit_mask = bmu_word_t'(1) << shamt;

    // Result select
    always_comb begin
        case (bmu_opcode_i)
            BMU_OP_CLZ,
            BMU_OP_CTZ:   bmu_result_o = bmu_word_t'(clz_ctz_res);
            BMU_OP_CPOP:  bmu_result_o = bmu_word_t'(cpop_res);
            BMU_OP_ORCB:  bmu_result_o = orc_b_res;
            BMU_OP_REV8:  bmu_result_o = rev8_res;
            BMU_OP_ZEXTH,
            BMU_OP_SEXTH: bmu_result_o = ext_h_res;
            BMU_OP_SEXTB: bmu_result_o = sext_b_res;
            BMU_OP_ROL:   bmu_result_o = rol_res;
            BMU_OP_ROR:   bmu_result_o = ror_res;
            BMU_OP_MAX:   bmu_result_o = lt_signed ? rs2_value_i : rs1_value_i;
            BMU_OP_MAXU:  bmu_result_o = lt_unsigned ? rs2_value_i : rs1_value_i;
            BMU_OP_MIN:   bmu_result_o = lt_signed ? rs1_value_i : rs2_value_i;
            BMU_OP_MINU:  bmu_result_o = lt_unsigned ? rs1_value_i : rs2_value_i;
            BMU_OP_BCLR:  bmu_result_o = rs1_value_i & ~bit_mask;
            BMU_OP_BEXT:  bmu_result_o = bmu_word_t'(|(rs1_value_i & bit_mask));
            BMU_OP_BINV:  bmu_result_o = rs1_value_i ^ bit_mask;
            BMU_OP_BSET:  bmu_result_o = rs1_value_i | bit_mask;
            default:      bmu_result_o = '0;  // Unused codes
        endcase
    end

endmodule

/* rtl/bmu_decoder.sv */
`timescale 1ns/1ps

module bmu_decoder import rv_isa_pkg::*, bmu_pkg::*; (
    input  rv_instr_t   instr_i,
    output bmu_op_t     op_o,
    output logic        use_imm_o,
    output rv_reg_idx_t rd_o,
    output logic        illegal_o
);

    rv_opcode_t  opcode;
    rv_funct3_t  funct3;
    rv_funct7_t  funct7;
    rv_reg_idx_t rs2_field;  // Also shamt / unary select

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7    = instr_i[31:25];
    assign rs2_field = instr_i[24:20];
    assign rd_o      = instr_i[11:7];  // Passed on even when illegal

    always_comb begin
        op_o      = BMU_OP_CLZ;  // Code 0 for anything unmatched
        use_imm_o = 1'b0;
        illegal_o = 1'b1;
        case (opcode)
            RV_OPC_OP: begin
                illegal_o = 1'b0;
                case ({funct7, funct3})
                    {RV_F7_ROT,    RV_F3_ROL}:  op_o = BMU_OP_ROL;
                    {RV_F7_ROT,    RV_F3_ROR}:  op_o = BMU_OP_ROR;
                    {RV_F7_MINMAX, RV_F3_MAX}:  op_o = BMU_OP_MAX;
                    {RV_F7_MINMAX, RV_F3_MAXU}: op_o = BMU_OP_MAXU;
                    {RV_F7_MINMAX, RV_F3_MIN}:  op_o = BMU_OP_MIN;
                    {RV_F7_MINMAX, RV_F3_MINU}: op_o = BMU_OP_MINU;
                    {RV_F7_BCLR,   RV_F3_BCLR}: op_o = BMU_OP_BCLR;
                    {RV_F7_BCLR,   RV_F3_BEXT}: op_o = BMU_OP_BEXT;
                    {RV_F7_BINV,   RV_F3_BINV}: op_o = BMU_OP_BINV;
                    {RV_F7_BSET,   RV_F3_BSET}: op_o = BMU_OP_BSET;
                    {RV_F7_ZEXTH, RV_F3_ZEXTH}: begin
                        op_o      = BMU_OP_ZEXTH;
                        illegal_o = (rs2_field != RV_RS2_ZEXTH);  // rs2 field must be 0
                    end
                    default: illegal_o = 1'b1;
                endcase
            end
            RV_OPC_OP_IMM: begin
                illegal_o = 1'b0;
                use_imm_o = 1'b1;  // Cleared again for the unary group
                case ({funct7, funct3})
                    {RV_F7_ROT,  RV_F3_ROR}:  op_o = BMU_OP_ROR;  // rori
                    {RV_F7_BCLR, RV_F3_BCLR}: op_o = BMU_OP_BCLR;
                    {RV_F7_BCLR, RV_F3_BEXT}: op_o = BMU_OP_BEXT;
                    {RV_F7_BINV, RV_F3_BINV}: op_o = BMU_OP_BINV;
                    {RV_F7_BSET, RV_F3_BSET}: op_o = BMU_OP_BSET;
                    {RV_F7_ROT, RV_F3_ROL}: begin
                        use_imm_o = 1'b0;
                        case (rs2_field)  // Unary select in the rs2 slot
                            RV_RS2_CLZ:   op_o = BMU_OP_CLZ;
                            RV_RS2_CTZ:   op_o = BMU_OP_CTZ;
                            RV_RS2_CPOP:  op_o = BMU_OP_CPOP;
                            RV_RS2_SEXTB: op_o = BMU_OP_SEXTB;
                            RV_RS2_SEXTH: op_o = BMU_OP_SEXTH;
                            default:      illegal_o = 1'b1;
                        endcase
                    end
                    {RV_F7_ORCB, RV_F3_ROR}: begin
                        use_imm_o = 1'b0;
                        op_o      = BMU_OP_ORCB;
                        illegal_o = (rs2_field != RV_RS2_ORCB);
                    end
                    {RV_F7_REV8, RV_F3_ROR}: begin
                        use_imm_o = 1'b0;
                        op_o      = BMU_OP_REV8;
                        illegal_o = (rs2_field != RV_RS2_REV8);
                    end
                    default: begin
                        use_imm_o = 1'b0;
                        illegal_o = 1'b1;
                    end
                endcase
            end
            default: illegal_o = 1'b1;  // Not an OP or OP-IMM word
        endcase
        if (illegal_o) begin
            op_o = BMU_OP_CLZ;
        end
    end

endmodule

/* rtl/bmu_unit.sv */
`timescale 1ns/1ps

module bmu_unit import rv_isa_pkg::*, bmu_pkg::*; #(
    parameter int XLEN_ONES_W = 6
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  bmu_issue_t  issue_i,
    output bmu_result_t result_o
);

    // Decoded operands held in the issue stage
    typedef struct packed {
        rv_reg_idx_t rd;
        bmu_op_t     op;
        bmu_word_t   rs1_value;
        bmu_word_t   rs2_value;  // Register value or immediate
    } exec_data_t;

    bmu_op_t     dec_op;
    logic        dec_use_imm;
    rv_reg_idx_t dec_rd;
    logic        dec_illegal;
    bmu_word_t   rs2_sel;       // Operand 2 after immediate select
    logic        exec_valid_q;
    logic        exec_illegal_q;
    exec_data_t  exec_q;
    bmu_word_t   bmu_value;     // Unit output for the issue stage
    logic        res_valid_q;
    logic        res_illegal_q;
    rv_reg_idx_t res_rd_q;
    bmu_word_t   res_value_q;

    bmu_decoder bmu_decoder_i (
        .instr_i   (issue_i.instr),
        .op_o      (dec_op),
        .use_imm_o (dec_use_imm),
        .rd_o      (dec_rd),
        .illegal_o (dec_illegal)
    );

    // Immediate field zero-extended into operand 2
    assign rs2_sel = dec_use_imm ? bmu_word_t'(issue_i.instr[24:20]) : issue_i.rs2_value;

    // Issue stage control
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exec_valid_q   <= 1'b0;
            exec_illegal_q <= 1'b0;
        end else begin
            exec_valid_q   <= issue_i.valid;
            exec_illegal_q <= issue_i.valid & dec_illegal;  // Only flagged for real items
        end
    end

    always_ff @(posedge clk_i) begin
        exec_q <= '{rd: dec_rd, op: dec_op, rs1_value: issue_i.rs1_value, rs2_value: rs2_sel};
    end

    bmu #(
        .XLEN_ONES_W (XLEN_ONES_W)
    ) bmu_i (
        .rs1_value_i  (exec_q.rs1_value),
        .rs2_value_i  (exec_q.rs2_value),
        .bmu_opcode_i (exec_q.op),
        .bmu_result_o (bmu_value)
    );

    // Result stage control
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q   <= 1'b0;
            res_illegal_q <= 1'b0;
        end else begin
            res_valid_q   <= exec_valid_q;
            res_illegal_q <= exec_illegal_q;
        end
    end

    always_ff @(posedge clk_i) begin
        res_rd_q    <= exec_q.rd;
        res_value_q <= exec_illegal_q ? '0 : bmu_value;  // Illegal items return 0
    end

    assign result_o = '{valid: res_valid_q, illegal: res_illegal_q, rd: res_rd_q,
                        value: res_value_q};

endmodule

/* sim/bmu_ref_model.svh */
// Mnemonic indices for encode_instr
localparam int MN_CLZ   = 0;
localparam int MN_CTZ   = 1;
localparam int MN_CPOP  = 2;
localparam int MN_ORCB  = 3;
localparam int MN_REV8  = 4;
localparam int MN_ZEXTH = 5;
localparam int MN_SEXTB = 6;
localparam int MN_SEXTH = 7;
localparam int MN_ROL   = 8;
localparam int MN_ROR   = 9;
localparam int MN_RORI  = 10;
localparam int MN_MAX   = 11;
localparam int MN_MAXU  = 12;
localparam int MN_MIN   = 13;
localparam int MN_MINU  = 14;
localparam int MN_BCLR  = 15;
localparam int MN_BCLRI = 16;
localparam int MN_BEXT  = 17;
localparam int MN_BEXTI = 18;
localparam int MN_BINV  = 19;
localparam int MN_BINVI = 20;
localparam int MN_BSET  = 21;
localparam int MN_BSETI = 22;
localparam int MN_COUNT = 23;

// Builds an R-type or I-type word; imm fills the rs2 slot of shift-immediate forms
function automatic rv_instr_t encode_instr(input int mn, input rv_reg_idx_t rd,
                                           input rv_reg_idx_t rs1, input rv_reg_idx_t rs2,
                                           input logic [4:0] imm);
    rv_opcode_t  opc;
    rv_funct3_t  f3;
    rv_funct7_t  f7;
    rv_reg_idx_t fld;
    opc = RV_OPC_OP;
    fld = rs2;
    case (mn)
        MN_CLZ:   {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_ROT, RV_F3_ROL, RV_RS2_CLZ};
        MN_CTZ:   {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_ROT, RV_F3_ROL, RV_RS2_CTZ};
        MN_CPOP:  {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_ROT, RV_F3_ROL, RV_RS2_CPOP};
        MN_SEXTB: {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_ROT, RV_F3_ROL, RV_RS2_SEXTB};
        MN_SEXTH: {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_ROT, RV_F3_ROL, RV_RS2_SEXTH};
        MN_ORCB:  {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_ORCB, RV_F3_ROR, RV_RS2_ORCB};
        MN_REV8:  {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_REV8, RV_F3_ROR, RV_RS2_REV8};
        MN_ZEXTH: {f7, f3, fld} = {RV_F7_ZEXTH, RV_F3_ZEXTH, RV_RS2_ZEXTH};
        MN_ROL:   {f7, f3} = {RV_F7_ROT, RV_F3_ROL};
        MN_ROR:   {f7, f3} = {RV_F7_ROT, RV_F3_ROR};
        MN_RORI:  {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_ROT, RV_F3_ROR, imm};
        MN_MAX:   {f7, f3} = {RV_F7_MINMAX, RV_F3_MAX};
        MN_MAXU:  {f7, f3} = {RV_F7_MINMAX, RV_F3_MAXU};
        MN_MIN:   {f7, f3} = {RV_F7_MINMAX, RV_F3_MIN};
        MN_MINU:  {f7, f3} = {RV_F7_MINMAX, RV_F3_MINU};
        MN_BCLR:  {f7, f3} = {RV_F7_BCLR, RV_F3_BCLR};
        MN_BCLRI: {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_BCLR, RV_F3_BCLR, imm};
        MN_BEXT:  {f7, f3} = {RV_F7_BCLR, RV_F3_BEXT};
        MN_BEXTI: {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_BCLR, RV_F3_BEXT, imm};
        MN_BINV:  {f7, f3} = {RV_F7_BINV, RV_F3_BINV};
        MN_BINVI: {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_BINV, RV_F3_BINV, imm};
        MN_BSET:  {f7, f3} = {RV_F7_BSET, RV_F3_BSET};
        default:  {opc, f7, f3, fld} = {RV_OPC_OP_IMM, RV_F7_BSET, RV_F3_BSET, imm};  // bseti
    endcase
    return {f7, fld, rs1, f3, rd, opc};
endfunction

// Expected result straight from the Zbb/Zbs encodings and their definitions
function automatic bmu_result_t bmu_expect(input rv_instr_t instr, input bmu_word_t a,
                                           input bmu_word_t b_reg);
    logic [6:0]  opc;
    logic [9:0]  fn;       // {funct7, funct3}
    logic [4:0]  r2;
    logic [4:0]  s;        // Index or amount
    bmu_word_t   b;
    bmu_word_t   v;
    logic        ok;
    logic [63:0] dbl;
    int          n;
    logic        hit;
    opc = instr[6:0];
    fn  = {instr[31:25], instr[14:12]};
    r2  = instr[24:20];
    b   = (opc == 7'h13) ? {27'b0, r2} : b_reg;  // Immediate forms ignore rs2
    s   = b[4:0];
    dbl = {a, a};
    ok  = 1'b1;
    v   = '0;
    n   = 0;
    hit = 1'b0;
    if (opc == 7'h33) begin
        case (fn)
            {7'h30, 3'd1}: v = dbl[(32 - s) +: 32];  // rol
            {7'h30, 3'd5}: v = dbl[s +: 32];         // ror
            {7'h05, 3'd6}: v = ($signed(a) > $signed(b)) ? a : b;
            {7'h05, 3'd7}: v = (a > b) ? a : b;
            {7'h05, 3'd4}: v = ($signed(a) < $signed(b)) ? a : b;
            {7'h05, 3'd5}: v = (a < b) ? a : b;
            {7'h24, 3'd1}: v = a & ~(32'h1 << s);
            {7'h24, 3'd5}: v = {31'b0, a[s]};
            {7'h34, 3'd1}: v = a ^ (32'h1 << s);
            {7'h14, 3'd1}: v = a | (32'h1 << s);
            {7'h04, 3'd4}: begin
                ok = (r2 == 5'd0);
                v  = {16'b0, a[15:0]};  // zext.h
            end
            default: ok = 1'b0;
        endcase
    end else if (opc == 7'h13) begin
        case (fn)
            {7'h30, 3'd5}: v = dbl[s +: 32];  // rori
            {7'h24, 3'd1}: v = a & ~(32'h1 << s);
            {7'h24, 3'd5}: v = {31'b0, a[s]};
            {7'h34, 3'd1}: v = a ^ (32'h1 << s);
            {7'h14, 3'd1}: v = a | (32'h1 << s);
            {7'h14, 3'd5}: begin
                ok = (r2 == 5'd7);
                for (int k = 0; k < 4; k++) v[8*k +: 8] = {8{|a[8*k +: 8]}};  // orc.b
            end
            {7'h34, 3'd5}: begin
                ok = (r2 == 5'd24);
                v  = {a[7:0], a[15:8], a[23:16], a[31:24]};  // rev8
            end
            {7'h30, 3'd1}: begin
                case (r2)
                    5'd0: begin
                        for (int i = 31; i >= 0; i--) begin
                            if (a[i]) hit = 1'b1;
                            if (!hit) n++;
                        end
                        v = 32'(n);  // clz
                    end
                    5'd1: begin
                        for (int i = 0; i < 32; i++) begin
                            if (a[i]) hit = 1'b1;
                            if (!hit) n++;
                        end
                        v = 32'(n);  // ctz
                    end
                    5'd2: begin
                        for (int i = 0; i < 32; i++) n += int'(a[i]);
                        v = 32'(n);  // cpop
                    end
                    5'd4: v = {{24{a[7]}}, a[7:0]};
                    5'd5: v = {{16{a[15]}}, a[15:0]};
                    default: ok = 1'b0;
                endcase
            end
            default: ok = 1'b0;
        endcase
    end else begin
        ok = 1'b0;
    end
    return '{valid: 1'b1, illegal: !ok, rd: instr[11:7], value: ok ? v : '0};
endfunction

/* sim/tb_bmu_unit.sv */
`timescale 1ns/1ps

module tb_bmu_unit import rv_isa_pkg::*, bmu_pkg::*; ();

    `include "bmu_ref_model.svh"

    logic        clk_i;
    logic        rst_n_i;
    bmu_issue_t  issue_i;
    bmu_result_t result_o;

    bmu_result_t exp_q [$];  // Expected results in issue order
    int          due_q [$];  // Cycle in which each result is due
    string       name_q [$];
    int          cycles;
    int          issued_count;
    int          checks;
    int          errors;
    int          tests;
    string       cur_test;
    int          test_checks;
    int          test_errors;

    bmu_unit #(
        .XLEN_ONES_W (6)
    ) bmu_unit_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .issue_i  (issue_i),
        .result_o (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;  // 40 ns period
    end

    // Cycle count and run limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > issued_count + 50) begin
            $display("Timeout: run exceeded %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // Compare each valid output with the queue head, half a cycle after the edge
    always @(negedge clk_i) begin
        if (rst_n_i && result_o.valid) begin
            checks++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Valid output in cycle %0d with no item pending", cycles);
            end else begin
                if (cycles != due_q[0]) begin
                    errors++;
                    $display("Test %s: result came in cycle %0d, due in cycle %0d",
                             name_q[0], cycles, due_q[0]);
                end
                if (result_o != exp_q[0]) begin
                    errors++;
                    $display("Error test %s: expected %h actual %h", name_q[0], exp_q[0],
                             result_o);
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    task automatic issue_item(input string name, input rv_instr_t instr, input bmu_word_t rs1,
                              input bmu_word_t rs2);
        @(posedge clk_i);
        #2;
        issue_i = '{valid: 1'b1, instr: instr, rs1_value: rs1, rs2_value: rs2};
        exp_q.push_back(bmu_expect(instr, rs1, rs2));
        due_q.push_back(cycles + 2);  // Two cycles from issue to result
        name_q.push_back(name);
        issued_count++;
    endtask

    // Random register indices around a fixed mnemonic
    task automatic issue_op(input int mn, input bmu_word_t rs1, input bmu_word_t rs2,
                            input logic [4:0] imm);
        rv_instr_t instr;
        instr = encode_instr(mn, 5'($urandom), 5'($urandom), 5'($urandom), imm);
        issue_item(cur_test, instr, rs1, rs2);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test();
        @(posedge clk_i);
        #2;
        issue_i.valid = 1'b0;
        for (int i = 0; i < 4 && exp_q.size() != 0; i++) begin
            @(negedge clk_i);  // Drain the pipeline
        end
        @(negedge clk_i);
        tests++;
        $display("Test %s done: %0d checks, %0d errors", cur_test, checks - test_checks,
                 errors - test_errors);
    endtask

    function automatic rv_instr_t random_illegal();
        rv_instr_t   w;
        bmu_result_t r;
        w = $urandom;
        if ($urandom % 2 == 0) w[6:0] = ($urandom % 2 == 0) ? RV_OPC_OP : RV_OPC_OP_IMM;
        r = bmu_expect(w, '0, '0);
        while (!r.illegal) begin
            w = $urandom;
            r = bmu_expect(w, '0, '0);
        end
        return w;
    endfunction

    initial begin
        bmu_word_t words [5];
        int        mn;
        void'($urandom(85));
        rst_n_i = 1'b0;
        issue_i = '0;
        cycles = 0;
        issued_count = 0;
        checks = 0;
        errors = 0;
        tests = 0;

        start_test("reset");
        repeat (3) begin
            @(negedge clk_i);
            checks++;
            if (result_o.valid || result_o.illegal) begin
                errors++;
                $display("Result valid or illegal set during reset");
            end
        end
        @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        checks++;
        if (result_o.valid) begin
            errors++;
            $display("Result valid set in the first cycle after reset");
        end
        issue_op(MN_CPOP, 32'h0000_00ff, '0, '0);  // Latency checked by the checker
        finish_test();

        start_test("count_extend");
        words[0] = '0;
        words[1] = '1;
        words[2] = 32'h1 << ($urandom % 32);
        words[3] = $urandom;
        words[4] = $urandom;
        for (int i = 0; i < 5; i++) begin
            issue_op(MN_CLZ, words[i], $urandom, '0);
            issue_op(MN_CTZ, words[i], $urandom, '0);
            issue_op(MN_CPOP, words[i], $urandom, '0);
        end
        issue_op(MN_ZEXTH, 32'h1234_8765, $urandom, '0);
        issue_op(MN_ZEXTH, 32'hffff_7654, $urandom, '0);
        issue_op(MN_SEXTH, 32'h1234_8765, $urandom, '0);
        issue_op(MN_SEXTH, 32'hffff_7654, $urandom, '0);
        issue_op(MN_SEXTB, 32'h0000_0080, $urandom, '0);
        issue_op(MN_SEXTB, 32'hffff_ff7f, $urandom, '0);
        repeat (4) begin
            issue_op(MN_ORCB, $urandom & 32'hff00_0ff0, $urandom, '0);
            issue_op(MN_REV8, $urandom, $urandom, '0);
        end
        finish_test();

        start_test("rotate_minmax");
        issue_op(MN_ROL, $urandom, $urandom & 32'hffff_ffe0, '0);  // Amount 0
        issue_op(MN_ROR, $urandom, 32'h0000_0000, '0);
        issue_op(MN_ROL, $urandom, 32'hffff_ffff, '0);  // Amount 31
        issue_op(MN_ROR, $urandom, 32'h0000_001f, '0);
        issue_op(MN_RORI, $urandom, $urandom, 5'd0);
        issue_op(MN_RORI, $urandom, $urandom, 5'd31);
        repeat (4) begin
            issue_op(MN_ROL, $urandom, $urandom, '0);
            issue_op(MN_ROR, $urandom, $urandom, '0);
            issue_op(MN_RORI, $urandom, $urandom, 5'($urandom));
        end
        for (mn = MN_MAX; mn <= MN_MINU; mn++) begin
            issue_op(mn, 32'h8000_0001, 32'h0000_0005, '0);
            issue_op(mn, 32'h0000_0005, 32'hffff_fff0, '0);
            issue_op(mn, 32'h1234_5678, 32'h1234_5678, '0);
            issue_op(mn, $urandom, $urandom, '0);
        end
        finish_test();

        start_test("single_bit");
        for (int idx = 0; idx < 32; idx++) begin
            for (mn = MN_BCLR; mn <= MN_BSETI; mn++) begin
                if ((mn - MN_BCLR) % 2 == 0) begin
                    issue_op(mn, $urandom, ($urandom & 32'hffff_ffe0) | 32'(idx), '0);
                end else begin
                    issue_op(mn, $urandom, $urandom, 5'(idx));  // rs2 value is noise
                end
            end
        end
        finish_test();

        start_test("illegal");
        repeat (20) issue_item(cur_test, random_illegal(), $urandom, $urandom);
        finish_test();

        start_test("stream");
        repeat (300) begin
            if ($urandom % 4 == 0) begin
                issue_item(cur_test, random_illegal(), $urandom, $urandom);
            end else begin
                issue_op(int'($urandom % MN_COUNT), $urandom, $urandom, 5'($urandom));
            end
        end
        finish_test();

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results never came out", exp_q.size());
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* compile.f */
rtl/rv_isa_pkg.sv
rtl/bmu_pkg.sv
rtl/bmu_clz.sv
rtl/bmu_cpop.sv
rtl/bmu.sv
rtl/bmu_decoder.sv
rtl/bmu_unit.sv
+incdir+sim
sim/tb_bmu_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

verilator --binary --timing -f compile.f --top-module tb_bmu_unit -o tb_bmu_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_bmu_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
exit 0
